/* run_sim.sh */
#!/bin/sh
# build and run the wb_stage testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_wb_stage -Mdir obj_dir -f wb_stage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_wb_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* source/wb_pkg.sv */
package wb_pkg;

    localparam int DEST_W = 3;  // gpr / sreg index
    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int SEL_W  = 16;
    localparam int TYPE_W = 4;

    // far pointer layout of a 64-bit slot
    typedef struct packed {
        logic [DATA_W-SEL_W-ADDR_W-1:0] pad;
        logic [SEL_W-1:0]               sel;
        logic [ADDR_W-1:0]              offset;
    } far_ptr_t;

    typedef union packed {
        logic [DATA_W-1:0] data;
        far_ptr_t          far;   // only when cs:eip gets loaded
    } wb_value_u;

    typedef struct packed {
        wb_value_u         value;
        logic [ADDR_W-1:0] dest;  // reg index in low bits, or mem address
        logic              is_reg;
        logic              is_seg;
        logic              is_mem;
        logic              wb;
    } wb_slot_t;

    typedef struct packed {
        logic far_jmp;
        logic far_ret;
        logic far_call;
        logic halt;
        logic iretd;
    } wb_uop_t;

    typedef struct packed {
        logic              valid;
        logic              taken;
        logic              correct;
        logic [ADDR_W-1:0] fip;
        logic [ADDR_W-1:0] fip_p1;  // next fetch line
    } wb_branch_t;

    typedef struct packed {
        logic              ie;
        logic [TYPE_W-1:0] ie_type;
    } wb_ie_t;

endpackage

/* source/wb_redirect.sv */
`timescale 1ns/1ns

module wb_redirect (
    input  logic [wb_pkg::ADDR_W-1:0] eip,
    input  wb_pkg::wb_branch_t        branch,
    input  logic [wb_pkg::ADDR_W-1:0] slot0_offset,
    input  logic                      ld_eip_cs,
    input  logic                      valid_in,
    input  logic                      valid_out,
    output logic [wb_pkg::ADDR_W-1:0] new_fip_even,
    output logic [wb_pkg::ADDR_W-1:0] new_fip_odd,
    output logic [wb_pkg::ADDR_W-1:0] new_eip,
    output logic                      br_valid,
    output logic                      br_taken,
    output logic                      br_correct,
    output logic                      resteer
);

    logic [wb_pkg::ADDR_W-1:0] fip_line;
    logic [wb_pkg::ADDR_W-1:0] fip_p1_line;
    logic [wb_pkg::ADDR_W-1:0] target_eip;

    // 16 byte fetch lines
    assign fip_line    = {branch.fip[wb_pkg::ADDR_W-1:4], 4'd0};
    assign fip_p1_line = {branch.fip_p1[wb_pkg::ADDR_W-1:4], 4'd0};

    // bit 4 picks which bank the target line sits in
    always_comb begin
        if (branch.fip[4]) begin
            new_fip_even = fip_p1_line;
            new_fip_odd  = fip_line;
        end else begin
            new_fip_even = fip_line;
            new_fip_odd  = fip_p1_line;
        end
    end

    assign target_eip = ld_eip_cs ? slot0_offset : branch.fip;  // far target from slot 0
    assign new_eip    = branch.taken ? target_eip : eip;

    assign br_valid   = branch.valid & valid_out;
    assign br_taken   = branch.taken;
    assign br_correct = branch.correct;

    // mispredict only matters on a retiring branch
    assign resteer = valid_in & br_valid & ~branch.correct;

endmodule

/* source/wb_retire.sv */
`timescale 1ns/1ns

module wb_retire #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      valid_in,
    input  wb_pkg::wb_uop_t           uop,
    input  wb_pkg::wb_ie_t            exc,
    input  logic                      idtr_orig,
    input  logic                      idtr_servicing,
    input  logic                      interrupt,
    input  logic                      wbaq_full,
    input  logic [NUM_SLOTS-1:0]      mem_req,
    input  logic [wb_pkg::ADDR_W-1:0] latched_eip,
    output logic                      valid_out,
    output logic                      stall,
    output logic                      final_ie_val,
    output logic [wb_pkg::TYPE_W-1:0] final_ie_type,
    output logic                      instr_is_final_wb,
    output logic                      halted,
    output logic [wb_pkg::ADDR_W-1:0] eip_hist1,
    output logic [wb_pkg::ADDR_W-1:0] eip_hist2
);

    logic ie_keep;  // exception not masked by idt service
    logic [wb_pkg::TYPE_W-2:0] ie_type_gated;

    // raw requests here, mem_ld would loop back through valid_out
    assign stall = wbaq_full & valid_in & (|mem_req);

    assign valid_out = (valid_in & ~stall & ~exc.ie) | (valid_in & idtr_orig);

    assign ie_keep       = valid_in & ~idtr_servicing;
    assign ie_type_gated = exc.ie_type[wb_pkg::TYPE_W-2:0] & {(wb_pkg::TYPE_W-1){ie_keep}};

    assign final_ie_val  = (exc.ie & ie_keep) | interrupt;
    assign final_ie_type = {interrupt, ie_type_gated};

    // last part of an idt-sourced sequence
    assign instr_is_final_wb = valid_in & idtr_orig & (uop.far_jmp | uop.far_ret);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (valid_out && uop.halt) begin
            halted <= 1'b1;  // sticky until reset
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            eip_hist1 <= '0;
            eip_hist2 <= '0;
        end else if (valid_out) begin
            eip_hist1 <= latched_eip;
            eip_hist2 <= eip_hist1;
        end
    end

endmodule

/* source/wb_route.sv */
`timescale 1ns/1ns

module wb_route #(
    parameter int NUM_SLOTS = 4
) (
    input  wb_pkg::wb_slot_t [NUM_SLOTS-1:0]                   slots,
    input  logic                                               valid_out,
    input  wb_pkg::wb_uop_t                                    uop,
    input  logic [1:0]                                         op_size,
    input  logic [3:0]                                         mem_size_ovr,
    output logic [NUM_SLOTS-1:0][wb_pkg::DATA_W-1:0]           res,
    output logic [1:0]                                         res_size,
    output logic [NUM_SLOTS-1:0][wb_pkg::DEST_W-1:0]           reg_addr,
    output logic [NUM_SLOTS-1:0][wb_pkg::DEST_W-1:0]           seg_addr,
    output logic [NUM_SLOTS-1:0]                               reg_ld,
    output logic [NUM_SLOTS-1:0]                               seg_ld,
    output logic [NUM_SLOTS-1:0]                               mem_req,
    output logic                                               mem_ld,
    output logic [wb_pkg::DATA_W-1:0]                          mem_data,
    output logic [wb_pkg::ADDR_W-1:0]                          mem_addr,
    output logic [1:0]                                         mem_size,
    output logic                                               ld_eip_cs
);

    assign ld_eip_cs = uop.far_jmp | uop.far_ret | uop.far_call;
    assign res_size  = op_size;

    genvar i;
    generate
        for (i = 0; i < NUM_SLOTS; i++) begin : g_slot
            assign reg_addr[i] = slots[i].dest[wb_pkg::DEST_W-1:0];
            assign seg_addr[i] = slots[i].dest[wb_pkg::DEST_W-1:0];
            assign reg_ld[i]   = slots[i].is_reg & slots[i].wb & valid_out;
            assign seg_ld[i]   = slots[i].is_seg & slots[i].wb & valid_out;
            assign mem_req[i]  = slots[i].is_mem & slots[i].wb;  // raw, feeds stall

            if (i == 0) begin : g_far
                // far transfer writes the selector to cs
                assign res[i] = ld_eip_cs ?
                    {{(wb_pkg::DATA_W-wb_pkg::SEL_W){1'b0}}, slots[i].value.far.sel} :
                    slots[i].value.data;
            end else begin : g_plain
                assign res[i] = slots[i].value.data;
            end
        end
    endgenerate

    assign mem_ld = |mem_req & valid_out;

    // lowest memory slot wins
    always_comb begin
        mem_data = '0;
        mem_addr = '0;
        for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
            if (mem_req[s]) begin
                mem_data = slots[s].value.data;
                mem_addr = slots[s].dest;
            end
        end
    end

    always_comb begin
        if (mem_size_ovr[0]) begin
            mem_size = 2'b00;
        end else if (mem_size_ovr[1]) begin
            mem_size = 2'b01;
        end else if (mem_size_ovr[2]) begin
            mem_size = 2'b10;
        end else if (mem_size_ovr[3] || ld_eip_cs) begin
            mem_size = 2'b11;  // far pointer push is 48 bits
        end else begin
            mem_size = op_size;
        end
    end

endmodule

/* source/wb_stage.sv */
`timescale 1ns/1ns

module wb_stage #(
    parameter int NUM_SLOTS = 4
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     valid_in,
    input  logic [wb_pkg::ADDR_W-1:0]                eip,
    input  logic [wb_pkg::ADDR_W-1:0]                latched_eip,
    input  wb_pkg::wb_uop_t                          uop,
    input  wb_pkg::wb_slot_t [NUM_SLOTS-1:0]         slots,
    input  logic [1:0]                               op_size,
    input  logic [3:0]                               mem_size_ovr,
    input  wb_pkg::wb_branch_t                       branch,
    input  wb_pkg::wb_ie_t                           exc,
    input  logic                                     idtr_orig,
    input  logic                                     idtr_servicing,
    input  logic                                     interrupt,
    input  logic                                     wbaq_full,
    output logic                                     valid_out,
    output logic                                     stall,
    output logic [NUM_SLOTS-1:0][wb_pkg::DATA_W-1:0] res,
    output logic [1:0]                               res_size,
    output logic [NUM_SLOTS-1:0][wb_pkg::DEST_W-1:0] reg_addr,
    output logic [NUM_SLOTS-1:0][wb_pkg::DEST_W-1:0] seg_addr,
    output logic [NUM_SLOTS-1:0]                     reg_ld,
    output logic [NUM_SLOTS-1:0]                     seg_ld,
    output logic                                     mem_ld,
    output logic [wb_pkg::DATA_W-1:0]                mem_data,
    output logic [wb_pkg::ADDR_W-1:0]                mem_addr,
    output logic [1:0]                               mem_size,
    output logic [wb_pkg::ADDR_W-1:0]                new_fip_even,
    output logic [wb_pkg::ADDR_W-1:0]                new_fip_odd,
    output logic [wb_pkg::ADDR_W-1:0]                new_eip,
    output logic                                     br_valid,
    output logic                                     br_taken,
    output logic                                     br_correct,
    output logic                                     resteer,
    output logic                                     final_ie_val,
    output logic [wb_pkg::TYPE_W-1:0]                final_ie_type,
    output logic                                     instr_is_final_wb,
    output logic                                     halted,
    output logic [wb_pkg::ADDR_W-1:0]                eip_hist1,
    output logic [wb_pkg::ADDR_W-1:0]                eip_hist2,
    output logic                                     is_iretd
);

    logic [NUM_SLOTS-1:0] mem_req;
    logic                 ld_eip_cs;

    assign is_iretd = uop.iretd;

    wb_route #(.NUM_SLOTS(NUM_SLOTS)) u_route (
        .slots        (slots),
        .valid_out    (valid_out),
        .uop          (uop),
        .op_size      (op_size),
        .mem_size_ovr (mem_size_ovr),
        .res          (res),
        .res_size     (res_size),
        .reg_addr     (reg_addr),
        .seg_addr     (seg_addr),
        .reg_ld       (reg_ld),
        .seg_ld       (seg_ld),
        .mem_req      (mem_req),
        .mem_ld       (mem_ld),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .mem_size     (mem_size),
        .ld_eip_cs    (ld_eip_cs)
    );

    wb_redirect u_redirect (
        .eip          (eip),
        .branch       (branch),
        .slot0_offset (slots[0].value.far.offset),  // far target offset
        .ld_eip_cs    (ld_eip_cs),
        .valid_in     (valid_in),
        .valid_out    (valid_out),
        .new_fip_even (new_fip_even),
        .new_fip_odd  (new_fip_odd),
        .new_eip      (new_eip),
        .br_valid     (br_valid),
        .br_taken     (br_taken),
        .br_correct   (br_correct),
        .resteer      (resteer)
    );

    wb_retire #(.NUM_SLOTS(NUM_SLOTS)) u_retire (
        .clk               (clk),
        .arst_n            (arst_n),
        .valid_in          (valid_in),
        .uop               (uop),
        .exc               (exc),
        .idtr_orig         (idtr_orig),
        .idtr_servicing    (idtr_servicing),
        .interrupt         (interrupt),
        .wbaq_full         (wbaq_full),
        .mem_req           (mem_req),
        .latched_eip       (latched_eip),
        .valid_out         (valid_out),
        .stall             (stall),
        .final_ie_val      (final_ie_val),
        .final_ie_type     (final_ie_type),
        .instr_is_final_wb (instr_is_final_wb),
        .halted            (halted),
        .eip_hist1         (eip_hist1),
        .eip_hist2         (eip_hist2)
    );

endmodule

/* testbench/tb_wb_stage.sv */
`timescale 1ns/1ns

module tb_wb_stage;

    localparam int NUM_SLOTS    = 4;
    localparam int HALT_TIMEOUT = 16;

    logic clk, arst_n, valid_in, idtr_orig, idtr_servicing, interrupt, wbaq_full;
    logic [wb_pkg::ADDR_W-1:0] eip, latched_eip;
    logic [1:0] op_size;
    logic [3:0] mem_size_ovr;
    wb_pkg::wb_uop_t uop;
    wb_pkg::wb_slot_t [NUM_SLOTS-1:0] slots;
    wb_pkg::wb_branch_t branch;
    wb_pkg::wb_ie_t exc;

    logic valid_out, stall, mem_ld, br_valid, br_taken, br_correct, resteer;
    logic final_ie_val, instr_is_final_wb, halted, is_iretd;
    logic [1:0] res_size, mem_size;
    logic [NUM_SLOTS-1:0] reg_ld, seg_ld;
    logic [NUM_SLOTS-1:0][wb_pkg::DATA_W-1:0] res;
    logic [NUM_SLOTS-1:0][wb_pkg::DEST_W-1:0] reg_addr, seg_addr;
    logic [wb_pkg::DATA_W-1:0] mem_data;
    logic [wb_pkg::ADDR_W-1:0] mem_addr, new_fip_even, new_fip_odd, new_eip;
    logic [wb_pkg::ADDR_W-1:0] eip_hist1, eip_hist2;
    logic [wb_pkg::TYPE_W-1:0] final_ie_type;

    int seed   = 77;
    int errors = 0;
    int checks = 0;

    wb_stage #(.NUM_SLOTS(NUM_SLOTS)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // quiet inputs, called right after a rising edge
    task automatic set_idle();
        {valid_in, idtr_orig, idtr_servicing, interrupt, wbaq_full} <= '0;
        {eip, latched_eip, uop, slots, branch, exc, mem_size_ovr} <= '0;
        op_size <= 2'b10;
    endtask

    // kind is {is_reg, is_seg, is_mem}
    task automatic make_slot(output wb_pkg::wb_slot_t s, input logic [2:0] kind);
        s.value.data = {$random(seed), $random(seed)};
        s.dest = $random(seed);
        {s.is_reg, s.is_seg, s.is_mem} = kind;
        s.wb = 1'b1;
    endtask

    task automatic test_routing();
        wb_pkg::wb_slot_t s [NUM_SLOTS];
        logic [NUM_SLOTS-1:0][2:0] exp_addr;
        make_slot(s[0], 3'b100);
        make_slot(s[1], 3'b010);
        make_slot(s[2], 3'b001);
        make_slot(s[3], 3'b001);  // higher mem slot loses
        for (int i = 0; i < NUM_SLOTS; i++) begin
            exp_addr[i] = s[i].dest[2:0];
        end
        @(posedge clk);
        set_idle();
        valid_in <= 1'b1;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slots[i] <= s[i];
        end
        @(negedge clk);
        check_value("reg_ld", 64'(reg_ld), 64'h1);
        check_value("seg_ld", 64'(seg_ld), 64'h2);
        check_value("mem_ld", 64'(mem_ld), 64'h1);
        check_value("reg_addr", 64'(reg_addr), 64'(exp_addr));
        check_value("seg_addr", 64'(seg_addr), 64'(exp_addr));
        for (int i = 0; i < NUM_SLOTS; i++) begin
            check_value($sformatf("res[%0d]", i), res[i], s[i].value.data);
        end
        check_value("mem_data", mem_data, s[2].value.data);
        check_value("mem_addr", 64'(mem_addr), 64'(s[2].dest));
        @(posedge clk);
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slots[i].wb <= 1'b0;
        end
        @(negedge clk);
        check_value("strobes", 64'({reg_ld, seg_ld, mem_ld}), 64'h0);
    endtask

    task automatic test_mem_size_far();
        wb_pkg::wb_slot_t s;
        make_slot(s, 3'b100);
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            set_idle();
            valid_in <= 1'b1;
            slots[0] <= s;
            uop.far_call <= 1'b1;  // override still wins
            mem_size_ovr <= 4'b0001 << k;
            @(negedge clk);
            check_value("mem_size", 64'(mem_size), 64'(k));
        end
        @(posedge clk);
        set_idle();
        valid_in <= 1'b1;
        op_size <= 2'b01;
        @(negedge clk);
        check_value("mem_size", 64'(mem_size), 64'h1);
        check_value("res_size", 64'(res_size), 64'h1);
        @(posedge clk);
        set_idle();
        valid_in <= 1'b1;
        slots[0] <= s;
        uop.far_jmp <= 1'b1;
        branch <= '{1'b1, 1'b1, 1'b1, 32'h0, 32'h10};
        @(negedge clk);
        check_value("mem_size", 64'(mem_size), 64'h3);
        check_value("res[0]", res[0], {48'd0, s.value.data[47:32]});
        check_value("new_eip", 64'(new_eip), 64'(s.value.data[31:0]));
    endtask

    task automatic test_branch(input logic bvalid, input logic taken, input logic correct,
                               input logic odd_line);
        logic [31:0] fip, fip_p1, cur_eip, line, line_p1;
        fip = $random(seed);
        fip[4] = odd_line;
        fip_p1 = fip + 32'd16;
        cur_eip = $random(seed);
        line = fip & ~32'hf;
        line_p1 = fip_p1 & ~32'hf;
        @(posedge clk);
        set_idle();
        valid_in <= 1'b1;
        eip <= cur_eip;
        branch <= '{bvalid, taken, correct, fip, fip_p1};
        @(negedge clk);
        check_value("new_fip_even", 64'(new_fip_even), 64'(odd_line ? line_p1 : line));
        check_value("new_fip_odd", 64'(new_fip_odd), 64'(odd_line ? line : line_p1));
        check_value("new_eip", 64'(new_eip), 64'(taken ? fip : cur_eip));
        check_value("br_valid", 64'(br_valid), 64'(bvalid));
        check_value("br_taken", 64'(br_taken), 64'(taken));
        check_value("br_correct", 64'(br_correct), 64'(correct));
        check_value("resteer", 64'(resteer), 64'(bvalid && !correct));
    endtask

    task automatic test_backpressure(input logic with_mem, input logic orig);
        wb_pkg::wb_slot_t s_reg, s_other;
        logic exp_valid;
        make_slot(s_reg, 3'b100);
        make_slot(s_other, with_mem ? 3'b001 : 3'b010);
        exp_valid = !with_mem || orig;
        @(posedge clk);
        set_idle();
        {valid_in, wbaq_full, idtr_orig} <= {1'b1, 1'b1, orig};
        uop.far_ret <= 1'b1;  // ends an idt sequence when orig is set
        slots[0] <= s_reg;
        slots[1] <= s_other;
        @(negedge clk);
        check_value("stall", 64'(stall), 64'(with_mem));
        check_value("valid_out", 64'(valid_out), 64'(exp_valid));
        check_value("reg_ld", 64'(reg_ld), 64'(exp_valid));
        check_value("seg_ld", 64'(seg_ld), 64'({exp_valid && !with_mem, 1'b0}));
        check_value("mem_ld", 64'(mem_ld), 64'(exp_valid && with_mem));
        check_value("instr_is_final_wb", 64'(instr_is_final_wb), 64'(orig));
    endtask

    task automatic test_exception(input logic ie, input logic servicing, input logic intr);
        logic [3:0] ie_type;
        ie_type = 4'($random(seed));
        @(posedge clk);
        set_idle();
        valid_in <= 1'b1;
        exc <= '{ie, ie_type};
        {idtr_servicing, interrupt} <= {servicing, intr};
        uop.iretd <= intr;
        @(negedge clk);
        check_value("valid_out", 64'(valid_out), 64'(!ie));
        check_value("final_ie_val", 64'(final_ie_val), 64'((ie && !servicing) || intr));
        check_value("final_ie_type", 64'(final_ie_type),
                    64'({intr, servicing ? 3'b000 : ie_type[2:0]}));
        check_value("is_iretd", 64'(is_iretd), 64'(intr));
    endtask

    task automatic test_history_halt();
        logic [31:0] first_eip, second_eip;
        wb_pkg::wb_slot_t s_mem;
        int waited;
        first_eip = $random(seed);
        second_eip = $random(seed);
        make_slot(s_mem, 3'b001);
        @(posedge clk);
        set_idle();
        valid_in <= 1'b1;
        latched_eip <= first_eip;
        @(posedge clk);
        latched_eip <= second_eip;
        @(posedge clk);
        latched_eip <= ~first_eip;  // stalled retire, must not shift in
        wbaq_full <= 1'b1;
        slots[0] <= s_mem;
        @(posedge clk);
        set_idle();
        @(negedge clk);
        check_value("eip_hist1", 64'(eip_hist1), 64'(second_eip));
        check_value("eip_hist2", 64'(eip_hist2), 64'(first_eip));
        @(posedge clk);
        valid_in <= 1'b1;
        uop.halt <= 1'b1;
        @(negedge clk);
        check_value("halted", 64'(halted), 64'h0);
        @(posedge clk);
        set_idle();
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!halted && waited < HALT_TIMEOUT);
        assert (halted && waited == 1) else begin
            errors++;
            $display("halted did not rise one clock after the halt retire, waited %0d", waited);
        end
    endtask

    initial begin
        arst_n <= 1'b0;
        set_idle();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("halted", 64'(halted), 64'h0);
        check_value("eip_hist1", 64'(eip_hist1), 64'h0);
        check_value("eip_hist2", 64'(eip_hist2), 64'h0);
        test_routing();
        test_mem_size_far();
        test_branch(1'b1, 1'b1, 1'b1, 1'b0);
        test_branch(1'b1, 1'b0, 1'b0, 1'b1);
        test_branch(1'b1, 1'b1, 1'b0, 1'b1);
        test_branch(1'b0, 1'b1, 1'b0, 1'b0);
        test_backpressure(1'b1, 1'b0);
        test_backpressure(1'b1, 1'b1);
        test_backpressure(1'b0, 1'b0);
        test_exception(1'b1, 1'b0, 1'b0);
        test_exception(1'b1, 1'b1, 1'b0);
        test_exception(1'b0, 1'b0, 1'b1);
        test_exception(1'b1, 1'b1, 1'b1);
        test_history_halt();
        @(negedge clk);
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut.u_asserts.fails);
        if (errors == 0 && dut.u_asserts.fails == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* testbench/wb_stage_asserts.sv */
`timescale 1ns/1ns

module wb_stage_asserts #(
    parameter int NUM_SLOTS = 4
) (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 valid_out,
    input logic [NUM_SLOTS-1:0] reg_ld,
    input logic [NUM_SLOTS-1:0] seg_ld,
    input logic                 mem_ld,
    input logic                 resteer,
    input logic                 br_valid,
    input logic                 halted
);

    int fails = 0;  // read by the testbench at the end

    strobe_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        !valid_out |-> (reg_ld == '0 && seg_ld == '0 && !mem_ld))
    else begin
        fails++;
        $error("load strobe high while valid_out is low");
    end

    resteer_needs_branch: assert property (@(posedge clk) disable iff (!arst_n)
        resteer |-> br_valid)
    else begin
        fails++;
        $error("resteer without a valid branch");
    end

    // sticky until reset
    halted_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        halted |=> halted)
    else begin
        fails++;
        $error("halted dropped without reset");
    end

endmodule

bind wb_stage wb_stage_asserts #(.NUM_SLOTS(NUM_SLOTS)) u_asserts (
    .clk       (clk),
    .arst_n    (arst_n),
    .valid_out (valid_out),
    .reg_ld    (reg_ld),
    .seg_ld    (seg_ld),
    .mem_ld    (mem_ld),
    .resteer   (resteer),
    .br_valid  (br_valid),
    .halted    (halted)
);

/* wb_stage.f */
source/wb_pkg.sv
source/wb_route.sv
source/wb_redirect.sv
source/wb_retire.sv
source/wb_stage.sv
testbench/wb_stage_asserts.sv
testbench/tb_wb_stage.sv
